// File: src/invaders_pkg.sv
/* invaders playfield definitions
   grid coordinate types, alien row geometry, fixed rows and config map */
package invaders_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // grid geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [4:0] col_t;                       // 32 columns across the playfield
   typedef logic [3:0] row_t;                       // 16 rows, row 0 is the top

   localparam int ALIEN_COUNT = 8;
   localparam int ALIEN_PITCH = 4;                  // columns from one alien to the next

   typedef logic [ALIEN_COUNT-1:0] alive_t;         // bit n set while alien n survives
   typedef logic [7:0]             score_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fixed positions
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam row_t SHIP_ROW        = 4'd13;        // fleet reaching this row ends the game
   localparam row_t LAUNCH_ROW      = 4'd12;        // first row of a fresh bullet
   localparam row_t PARK_ROW        = 4'd15;        // reported while no bullet is flying
   localparam row_t FLEET_START_ROW = 4'd1;
   localparam col_t SHIP_START_COL  = 5'd16;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // configuration register map
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [1:0] cfg_addr_t;

   localparam cfg_addr_t CFG_CTRL          = 2'd0;  // bit 0 is run
   localparam cfg_addr_t CFG_BULLET_PERIOD = 2'd1;
   localparam cfg_addr_t CFG_FLEET_PERIOD  = 2'd2;

endpackage

// File: src/shot_if.sv
/* bullet to fleet link
   carries the bullet position and the combinational hit answer */
`timescale 1ns/1ns

interface shot_if;
   import invaders_pkg::*;

   logic flying;                                    // a bullet is in the air
   col_t x;
   row_t y;
   logic hit;                                       // bullet sits on a live alien this cycle

   modport shooter (
      output flying,
      output x,
      output y,
      input  hit
   );

   modport target (
      input  flying,
      input  x,
      input  y,
      output hit
   );

endinterface

// File: src/tick_timer.sv
/* programmable step timer
   pulses one cycle out of every i_period cycles while enabled */
`timescale 1ns/1ns

module tick_timer #(
   parameter int PERIOD_W = 24
) (
   input  logic                i_clk_36MHz,
   input  logic                i_reset,
   input  logic                i_en,
   input  logic [PERIOD_W-1:0] i_period,
   output logic                o_tick
);

   logic [PERIOD_W-1:0] count;                      // cycles left until the next pulse
   logic [PERIOD_W-1:0] reload;

   assign reload = i_period - 1'b1;                 // a period of one pulses every cycle

   always_ff @(posedge i_clk_36MHz) begin
      if (!i_reset || !i_en) begin
         count  <= reload;
         o_tick <= 1'b0;
      end else if (count == '0) begin
         count  <= reload;                          // period changes take effect here
         o_tick <= 1'b1;
      end else begin
         count  <= count - 1'b1;
         o_tick <= 1'b0;
      end
   end

endmodule

// File: src/game_config.sv
/* game configuration registers
   run control plus bullet and fleet step periods, with combinational readback */
`timescale 1ns/1ns

module game_config #(
   parameter int PERIOD_W = 24
) (
   input  logic                   i_clk_36MHz,
   input  logic                   i_reset,
   input  logic                   i_cfg_we,
   input  invaders_pkg::cfg_addr_t i_cfg_addr,
   input  logic [PERIOD_W-1:0]    i_cfg_wdata,
   output logic [PERIOD_W-1:0]    o_cfg_rdata,
   output logic                   o_run,
   output logic [PERIOD_W-1:0]    o_bullet_period,
   output logic [PERIOD_W-1:0]    o_fleet_period
);
   import invaders_pkg::*;

   // about 2.5 ms per bullet row and 25 ms per fleet step at 36 MHz
   localparam logic [PERIOD_W-1:0] BULLET_PERIOD_RST = PERIOD_W'(90000);
   localparam logic [PERIOD_W-1:0] FLEET_PERIOD_RST  = PERIOD_W'(900000);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register writes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk_36MHz) begin
      if (!i_reset) begin
         o_run           <= 1'b0;                   // game waits until software starts it
         o_bullet_period <= BULLET_PERIOD_RST;
         o_fleet_period  <= FLEET_PERIOD_RST;
      end else if (i_cfg_we) begin
         case (i_cfg_addr)
            CFG_CTRL:          o_run           <= i_cfg_wdata[0];
            CFG_BULLET_PERIOD: o_bullet_period <= i_cfg_wdata;
            CFG_FLEET_PERIOD:  o_fleet_period  <= i_cfg_wdata;
            default:           ;                    // address 3 has no register behind it
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // readback
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      case (i_cfg_addr)
         CFG_CTRL:          o_cfg_rdata = {{(PERIOD_W-1){1'b0}}, o_run};
         CFG_BULLET_PERIOD: o_cfg_rdata = o_bullet_period;
         CFG_FLEET_PERIOD:  o_cfg_rdata = o_fleet_period;
         default:           o_cfg_rdata = '0;       // unmapped space reads as zero
      endcase
   end

endmodule

// File: src/ship_control.sv
/* player ship control
   steps the ship column on button edges and turns a shoot press into one fire pulse */
`timescale 1ns/1ns

module ship_control (
   input  logic               i_clk_36MHz,
   input  logic               i_reset,
   input  logic               i_left,
   input  logic               i_right,
   input  logic               i_shoot,
   output invaders_pkg::col_t o_ship_x,
   output logic               o_fire
);
   import invaders_pkg::*;

   localparam col_t MAX_COL = '1;                   // rightmost column of the grid

   logic left_q;                                    // button levels from the last cycle
   logic right_q;
   logic shoot_q;
   logic left_rise;
   logic right_rise;

   assign left_rise  = i_left  && !left_q;
   assign right_rise = i_right && !right_q;

   always_ff @(posedge i_clk_36MHz) begin
      if (!i_reset) begin
         left_q   <= 1'b0;
         right_q  <= 1'b0;
         shoot_q  <= 1'b0;
         o_ship_x <= SHIP_START_COL;
         o_fire   <= 1'b0;
      end else begin
         left_q   <= i_left;
         right_q  <= i_right;
         shoot_q  <= i_shoot;
         o_fire   <= i_shoot && !shoot_q;           // one cycle per press, however long it is held
         // opposite presses in the same cycle cancel out
         if (left_rise && !right_rise && o_ship_x != '0) begin
            o_ship_x <= o_ship_x - 1'b1;
         end else if (right_rise && !left_rise && o_ship_x != MAX_COL) begin
            o_ship_x <= o_ship_x + 1'b1;
         end
      end
   end

endmodule

// File: src/bullet.sv
/* single player bullet
   launches at the ship column, climbs one row per tick, retires on a hit or at the top */
`timescale 1ns/1ns

module bullet (
   input  logic               i_clk_36MHz,
   input  logic               i_reset,
   input  logic               i_enable,
   input  logic               i_fire,
   input  logic               i_tick,
   input  invaders_pkg::col_t i_ship_x,
   shot_if.shooter            shot
);
   import invaders_pkg::*;

   logic launch;
   logic retire;

   assign launch = !shot.flying && i_enable && i_fire;                // only one bullet at a time
   assign retire = shot.flying && (shot.hit || shot.y == '0);         // hit or left the playfield

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bullet state machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk_36MHz) begin
      if (!i_reset) begin
         shot.flying <= 1'b0;
         shot.x      <= '0;
         shot.y      <= PARK_ROW;
      end else if (launch) begin
         shot.flying <= 1'b1;
         shot.x      <= i_ship_x;                   // column is fixed for the whole flight
         shot.y      <= LAUNCH_ROW;
      end else if (retire) begin
         shot.flying <= 1'b0;
         shot.x      <= '0;
         shot.y      <= PARK_ROW;
      end else if (shot.flying && i_tick) begin
         shot.y      <= shot.y - 1'b1;              // one row closer to the top
      end
   end

endmodule

// File: src/alien_fleet.sv
/* alien fleet
   sweeps the eight alien row, resolves bullet hits, keeps score and flags game over */
`timescale 1ns/1ns

module alien_fleet (
   input  logic                 i_clk_36MHz,
   input  logic                 i_reset,
   input  logic                 i_enable,
   input  logic                 i_tick,
   shot_if.target               shot,
   output invaders_pkg::alive_t o_alive,
   output invaders_pkg::col_t   o_fleet_x,
   output invaders_pkg::row_t   o_fleet_y,
   output invaders_pkg::score_t o_score,
   output logic                 o_game_over
);
   import invaders_pkg::*;

   localparam int IDX_W = $clog2(ALIEN_COUNT);

   // the last alien has to stay on the grid, which leaves columns 0 to 3 for the fleet
   localparam col_t FLEET_MAX_COL =
      col_t'((2 ** $bits(col_t)) - 1 - (ALIEN_COUNT - 1) * ALIEN_PITCH);

   logic             moving_right;
   logic             step;
   col_t             offset;                        // bullet column relative to the fleet
   logic [IDX_W-1:0] alien_idx;
   logic             on_grid;
   logic             on_row;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // hit detection
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign offset    = shot.x - o_fleet_x;                   // only meaningful when x >= fleet x
   assign alien_idx = IDX_W'(offset / ALIEN_PITCH);
   assign on_row    = shot.flying && (shot.y == o_fleet_y);

   // bullet lines up with an alien slot, dead or alive
   assign on_grid = (shot.x >= o_fleet_x)
                 && ((offset % ALIEN_PITCH) == 0)
                 && ((offset / ALIEN_PITCH) < ALIEN_COUNT);

   assign shot.hit = on_row && on_grid && o_alive[alien_idx];

   assign step = i_tick && i_enable && !o_game_over;        // a finished game stays frozen

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fleet movement
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk_36MHz) begin
      if (!i_reset) begin
         o_fleet_x    <= '0;
         o_fleet_y    <= FLEET_START_ROW;
         moving_right <= 1'b1;
      end else if (step) begin
         if (moving_right) begin
            if (o_fleet_x == FLEET_MAX_COL) begin
               moving_right <= 1'b0;                // bounce off the right edge and drop a row
               o_fleet_y    <= o_fleet_y + 1'b1;
            end else begin
               o_fleet_x    <= o_fleet_x + 1'b1;
            end
         end else begin
            if (o_fleet_x == '0) begin
               moving_right <= 1'b1;
               o_fleet_y    <= o_fleet_y + 1'b1;
            end else begin
               o_fleet_x    <= o_fleet_x - 1'b1;
            end
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // alive mask, score and end of game
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk_36MHz) begin
      if (!i_reset) begin
         o_alive     <= '1;
         o_score     <= '0;
         o_game_over <= 1'b0;
      end else begin
         if (shot.hit) begin
            o_alive[alien_idx] <= 1'b0;              // bullet retires on the same edge
            o_score            <= o_score + 1'b1;
         end
         // sticky once the row is cleared or the fleet reaches the ship
         if (o_alive == '0 || o_fleet_y >= SHIP_ROW) begin
            o_game_over <= 1'b1;
         end
      end
   end

endmodule

// File: src/invaders_top.sv
/* invaders playfield core
   config registers, step timers, ship, bullet and fleet wired to plain ports */
`timescale 1ns/1ns

module invaders_top #(
   parameter int PERIOD_W = 24
) (
   input  logic                    i_clk_36MHz,
   input  logic                    i_reset,
   input  logic                    i_cfg_we,
   input  invaders_pkg::cfg_addr_t i_cfg_addr,
   input  logic [PERIOD_W-1:0]     i_cfg_wdata,
   output logic [PERIOD_W-1:0]     o_cfg_rdata,
   input  logic                    i_left,
   input  logic                    i_right,
   input  logic                    i_shoot,
   output invaders_pkg::col_t      o_ship_x,
   output logic                    o_bullet_flying,
   output invaders_pkg::col_t      o_bullet_x,
   output invaders_pkg::row_t      o_bullet_y,
   output invaders_pkg::alive_t    o_alien_alive,
   output invaders_pkg::col_t      o_fleet_x,
   output invaders_pkg::row_t      o_fleet_y,
   output invaders_pkg::score_t    o_score,
   output logic                    o_game_over
);

   logic                run;
   logic [PERIOD_W-1:0] bullet_period;
   logic [PERIOD_W-1:0] fleet_period;
   logic                bullet_tick;
   logic                fleet_tick;
   logic                fire;
   logic                game_enable;

   shot_if shot ();

   assign game_enable = run && !o_game_over;        // play only while started and not yet lost

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // configuration and timing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   game_config #(.PERIOD_W(PERIOD_W)) game_config_i (
      .i_clk_36MHz     (i_clk_36MHz),
      .i_reset         (i_reset),
      .i_cfg_we        (i_cfg_we),
      .i_cfg_addr      (i_cfg_addr),
      .i_cfg_wdata     (i_cfg_wdata),
      .o_cfg_rdata     (o_cfg_rdata),
      .o_run           (run),
      .o_bullet_period (bullet_period),
      .o_fleet_period  (fleet_period)
   );

   tick_timer #(.PERIOD_W(PERIOD_W)) bullet_timer_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_reset     (i_reset),
      .i_en        (game_enable),
      .i_period    (bullet_period),
      .o_tick      (bullet_tick)
   );

   tick_timer #(.PERIOD_W(PERIOD_W)) fleet_timer_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_reset     (i_reset),
      .i_en        (game_enable),
      .i_period    (fleet_period),
      .o_tick      (fleet_tick)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // playfield objects
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   ship_control ship_control_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_reset     (i_reset),
      .i_left      (i_left),
      .i_right     (i_right),
      .i_shoot     (i_shoot),
      .o_ship_x    (o_ship_x),
      .o_fire      (fire)
   );

   bullet bullet_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_reset     (i_reset),
      .i_enable    (game_enable),
      .i_fire      (fire),
      .i_tick      (bullet_tick),
      .i_ship_x    (o_ship_x),
      .shot        (shot.shooter)
   );

   alien_fleet alien_fleet_i (
      .i_clk_36MHz (i_clk_36MHz),
      .i_reset     (i_reset),
      .i_enable    (game_enable),
      .i_tick      (fleet_tick),
      .shot        (shot.target),
      .o_alive     (o_alien_alive),
      .o_fleet_x   (o_fleet_x),
      .o_fleet_y   (o_fleet_y),
      .o_score     (o_score),
      .o_game_over (o_game_over)
   );

   assign o_bullet_flying = shot.flying;            // bullet state broken out for display
   assign o_bullet_x      = shot.x;
   assign o_bullet_y      = shot.y;

endmodule

// File: verif/invaders_tb.sv
/* invaders playfield testbench
   drives config writes, buttons and shots into the core and checks it with assertions */
`timescale 1ns/1ns

module invaders_tb;
   import invaders_pkg::*;

   localparam int PERIOD_W  = 24;
   localparam int BTN_LEFT  = 0;
   localparam int BTN_RIGHT = 1;
   localparam int BTN_SHOOT = 2;

   logic                i_clk_36MHz;
   logic                i_reset;
   logic                i_cfg_we;
   cfg_addr_t           i_cfg_addr;
   logic [PERIOD_W-1:0] i_cfg_wdata;
   logic [PERIOD_W-1:0] o_cfg_rdata;
   logic                i_left;
   logic                i_right;
   logic                i_shoot;
   col_t                o_ship_x;
   logic                o_bullet_flying;
   col_t                o_bullet_x;
   row_t                o_bullet_y;
   alive_t              o_alien_alive;
   col_t                o_fleet_x;
   row_t                o_fleet_y;
   score_t              o_score;
   logic                o_game_over;

   string  test_name;
   logic   run_on;                                  // run bit as last written
   logic   reset_q = 1'b0;                          // checker view of the previous edge
   logic   last_flying;
   col_t   last_bx;
   row_t   last_by;
   col_t   last_fx;
   row_t   last_fy;
   alive_t last_alive;
   score_t last_score;
   logic   last_game_over;
   int     last_slot;                               // alien the bullet should hit, or -1

   invaders_top #(.PERIOD_W(PERIOD_W)) invaders_top_i (.*);

   initial begin
      i_clk_36MHz = 1'b0;
      forever #10 i_clk_36MHz = ~i_clk_36MHz;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // failure reporting and the hit rule
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "stopped at the first failing check");
   endtask

   task automatic value_error(input string what, input int expected, input int actual);
      stop_on_error($sformatf("ERR %s: %s expected %0d actual %0d",
                              test_name, what, expected, actual));
   endtask

   // slot of the live alien under the bullet, -1 when the bullet misses
   function automatic int hit_slot(input logic flying, input col_t bx, input row_t by,
                                   input col_t fx, input row_t fy, input alive_t alive);
      int offset;
      offset = int'(bx) - int'(fx);
      if (!flying || by != fy || offset < 0) return -1;
      if (offset % ALIEN_PITCH != 0 || offset / ALIEN_PITCH >= ALIEN_COUNT) return -1;
      if (!alive[offset / ALIEN_PITCH]) return -1;
      return offset / ALIEN_PITCH;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // cycle checker
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge i_clk_36MHz) begin
      if (i_reset && reset_q) begin
         if (last_slot >= 0) begin                  // hit on the previous edge
            assert (o_alien_alive == (last_alive & ~(alive_t'(1) << last_slot)))
               else value_error("alive mask after hit", last_alive & ~(1 << last_slot),
                                o_alien_alive);
            assert (o_score == score_t'(last_score + 1))
               else value_error("score after hit", last_score + 1, o_score);
            assert (!o_bullet_flying) else stop_on_error("bullet kept flying after a hit");
         end else begin
            assert (o_alien_alive == last_alive)
               else value_error("alive mask without hit", last_alive, o_alien_alive);
            assert (o_score == last_score)
               else value_error("score without hit", last_score, o_score);
            if (last_flying && last_by != 0) begin
               assert (o_bullet_flying)
                  else stop_on_error("bullet stopped flying without a hit");
               assert (o_bullet_x == last_bx)
                  else value_error("bullet column in flight", last_bx, o_bullet_x);
               assert (o_bullet_y == last_by || o_bullet_y + 1 == last_by)
                  else value_error("bullet row step", last_by - 1, o_bullet_y);
            end
            if (last_flying && last_by == 0)
               assert (!o_bullet_flying) else stop_on_error("bullet at the top did not retire");
         end
         if (o_fleet_x != last_fx || o_fleet_y != last_fy) begin
            assert ((o_fleet_y == last_fy && o_fleet_x <= 3
                     && (o_fleet_x == last_fx + 1 || o_fleet_x + 1 == last_fx))
                    || (o_fleet_y == last_fy + 1 && o_fleet_x == last_fx
                        && (last_fx == 0 || last_fx == 3)))
               else stop_on_error("fleet left its sweep path");
            assert (!last_game_over) else stop_on_error("fleet moved after game over");
         end
         if (last_game_over && !last_flying)
            assert (!o_bullet_flying) else stop_on_error("bullet launched after game over");
      end
      reset_q        = i_reset;
      last_slot      = hit_slot(o_bullet_flying, o_bullet_x, o_bullet_y,
                                o_fleet_x, o_fleet_y, o_alien_alive);
      last_flying    = o_bullet_flying;
      last_bx        = o_bullet_x;
      last_by        = o_bullet_y;
      last_fx        = o_fleet_x;
      last_fy        = o_fleet_y;
      last_alive     = o_alien_alive;
      last_score     = o_score;
      last_game_over = o_game_over;
   end

   // the fire pulse needs one edge and the launch one more
   launch_row: assert property (@(posedge i_clk_36MHz) disable iff (!i_reset)
      ($rose(i_shoot) && run_on && !o_game_over && !o_bullet_flying)
         |-> ##2 (o_bullet_flying && o_bullet_y == LAUNCH_ROW))
      else value_error("launch row", LAUNCH_ROW, $sampled(o_bullet_y));

   parked_col: assert property (@(posedge i_clk_36MHz) disable iff (!i_reset)
      !o_bullet_flying |-> o_bullet_x == '0)
      else value_error("parked bullet column", 0, $sampled(o_bullet_x));

   parked_row: assert property (@(posedge i_clk_36MHz) disable iff (!i_reset)
      !o_bullet_flying |-> o_bullet_y == PARK_ROW)
      else value_error("parked bullet row", PARK_ROW, $sampled(o_bullet_y));

   game_over_sticky: assert property (@(posedge i_clk_36MHz) disable iff (!i_reset)
      o_game_over |=> o_game_over)
      else stop_on_error("game over dropped without a reset");

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic apply_reset();
      run_on = 1'b0;
      @(posedge i_clk_36MHz);
      i_reset <= 1'b0;
      repeat (4) @(posedge i_clk_36MHz);
      i_reset <= 1'b1;
      @(posedge i_clk_36MHz);
   endtask

   task automatic write_cfg(input cfg_addr_t addr, input logic [PERIOD_W-1:0] data);
      @(posedge i_clk_36MHz);
      i_cfg_we    <= 1'b1;
      i_cfg_addr  <= addr;
      i_cfg_wdata <= data;
      @(posedge i_clk_36MHz);
      i_cfg_we    <= 1'b0;
   endtask

   task automatic read_check(input cfg_addr_t addr, input logic [PERIOD_W-1:0] expected);
      @(posedge i_clk_36MHz);
      i_cfg_addr <= addr;
      @(posedge i_clk_36MHz);
      assert (o_cfg_rdata == expected)
         else value_error($sformatf("read of address %0d", addr), expected, o_cfg_rdata);
   endtask

   // the register shows the new value one cycle after the write edge
   task automatic write_readback(input cfg_addr_t addr, input logic [PERIOD_W-1:0] data,
                                 input logic [PERIOD_W-1:0] expected);
      write_cfg(addr, data);
      @(posedge i_clk_36MHz);
      assert (o_cfg_rdata == expected)
         else value_error($sformatf("readback of address %0d", addr), expected, o_cfg_rdata);
   endtask

   task automatic press_button(input int which);
      @(posedge i_clk_36MHz);
      case (which)
         BTN_LEFT:  i_left  <= 1'b1;
         BTN_RIGHT: i_right <= 1'b1;
         default:   i_shoot <= 1'b1;
      endcase
      repeat (2) @(posedge i_clk_36MHz);
      i_left  <= 1'b0;
      i_right <= 1'b0;
      i_shoot <= 1'b0;
      repeat (2) @(posedge i_clk_36MHz);
   endtask

   task automatic step_ship(input logic go_right);
      col_t expected;
      if (go_right) expected = (o_ship_x == 5'd31) ? o_ship_x : o_ship_x + 1'b1;
      else          expected = (o_ship_x == 5'd0)  ? o_ship_x : o_ship_x - 1'b1;
      press_button(go_right ? BTN_RIGHT : BTN_LEFT);
      assert (o_ship_x == expected) else value_error("ship column", expected, o_ship_x);
   endtask

   task automatic move_ship_to(input col_t target);
      int guard;
      guard = 0;
      while (o_ship_x != target && guard < 40) begin
         step_ship(o_ship_x < target);
         guard++;
      end
      assert (o_ship_x == target) else value_error("ship target column", target, o_ship_x);
   endtask

   task automatic wait_bullet_parked(input int limit);
      int guard;
      guard = 0;
      while (o_bullet_flying && guard < limit) begin
         @(posedge i_clk_36MHz);
         guard++;
      end
      if (o_bullet_flying) stop_on_error("timeout waiting for the bullet to retire");
   endtask

   task automatic wait_game_over(input int limit);
      int guard;
      guard = 0;
      while (!o_game_over && guard < limit) begin
         @(posedge i_clk_36MHz);
         guard++;
      end
      if (!o_game_over) stop_on_error("timeout waiting for game over");
   endtask

   initial begin
      repeat (100000) @(posedge i_clk_36MHz);
      stop_on_error("watchdog expired before the test sequence finished");
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      int                  idx;
      int                  tries;
      col_t                col;
      col_t                fx_hold;
      row_t                fy_hold;
      logic [PERIOD_W-1:0] rnd;
      void'($urandom(32'hd6d7f28f));
      i_reset     = 1'b0;
      i_cfg_we    = 1'b0;
      i_cfg_addr  = '0;
      i_cfg_wdata = '0;
      i_left      = 1'b0;
      i_right     = 1'b0;
      i_shoot     = 1'b0;
      run_on      = 1'b0;
      test_name   = "reset state";
      apply_reset();
      assert (o_ship_x == SHIP_START_COL) else value_error("ship column", SHIP_START_COL, o_ship_x);
      assert (!o_bullet_flying) else stop_on_error("bullet flying after reset");
      assert (o_alien_alive == '1) else value_error("alive mask", 8'hff, o_alien_alive);
      assert (o_fleet_x == 0) else value_error("fleet column", 0, o_fleet_x);
      assert (o_fleet_y == FLEET_START_ROW)
         else value_error("fleet row", FLEET_START_ROW, o_fleet_y);
      assert (o_score == 0) else value_error("score", 0, o_score);
      assert (!o_game_over) else stop_on_error("game over set after reset");
      read_check(CFG_CTRL, '0);                     // run starts cleared
      read_check(CFG_BULLET_PERIOD, 90000);
      read_check(CFG_FLEET_PERIOD, 900000);

      test_name = "config registers";
      write_readback(2'd3, '1, '0);                 // unmapped address reads zero
      rnd = PERIOD_W'($urandom);
      write_readback(CFG_CTRL, rnd, rnd & 1);
      write_readback(CFG_CTRL, '0, '0);
      write_readback(CFG_BULLET_PERIOD, rnd, rnd);
      rnd = PERIOD_W'($urandom);
      write_readback(CFG_FLEET_PERIOD, rnd, rnd);

      test_name = "ship movement";
      apply_reset();
      repeat (18) step_ship(1'b1);                  // runs into the right clamp
      repeat (36) step_ship(1'b0);
      repeat (4) move_ship_to(col_t'($urandom % 32));

      test_name = "bullet flight";
      apply_reset();
      write_cfg(CFG_BULLET_PERIOD, 3);
      write_cfg(CFG_FLEET_PERIOD, 1000000);         // fleet parked at column 0
      write_cfg(CFG_CTRL, 1);
      run_on = 1'b1;
      col = col_t'(ALIEN_PITCH * ($urandom % ALIEN_COUNT) + 1 + $urandom % 3);
      move_ship_to(col);
      press_button(BTN_SHOOT);
      assert (o_bullet_flying) else stop_on_error("bullet did not launch");
      assert (o_bullet_x == col) else value_error("launch column", col, o_bullet_x);
      press_button(BTN_SHOOT);
      wait_bullet_parked(200);

      test_name = "fleet motion";
      apply_reset();
      write_cfg(CFG_FLEET_PERIOD, 2);
      write_cfg(CFG_CTRL, 1);
      run_on = 1'b1;
      wait_game_over(2000);                         // fleet marches down to the ship row
      assert (o_fleet_y == SHIP_ROW) else value_error("final fleet row", SHIP_ROW, o_fleet_y);
      repeat (20) @(posedge i_clk_36MHz);

      test_name = "game over";
      apply_reset();
      write_cfg(CFG_BULLET_PERIOD, 2);
      write_cfg(CFG_FLEET_PERIOD, 600);
      write_cfg(CFG_CTRL, 1);
      run_on = 1'b1;
      tries  = 0;
      while (o_alien_alive != '0 && tries < 40) begin
         idx = $urandom % ALIEN_COUNT;
         while (!o_alien_alive[idx]) idx = (idx + 1) % ALIEN_COUNT;
         move_ship_to(col_t'(o_fleet_x + ALIEN_PITCH * idx));
         press_button(BTN_SHOOT);
         wait_bullet_parked(400);                   // a fleet step during flight turns it into a miss
         tries++;
      end
      wait_game_over(50);
      assert (o_score == ALIEN_COUNT) else value_error("final score", ALIEN_COUNT, o_score);
      fx_hold = o_fleet_x;
      fy_hold = o_fleet_y;
      press_button(BTN_SHOOT);
      repeat (20) @(posedge i_clk_36MHz);
      assert (o_fleet_x == fx_hold && o_fleet_y == fy_hold)
         else stop_on_error("fleet moved after game over");

      test_name = "run cleared";
      apply_reset();
      write_cfg(CFG_BULLET_PERIOD, 1);
      write_cfg(CFG_FLEET_PERIOD, 1);
      press_button(BTN_SHOOT);
      repeat (50) @(posedge i_clk_36MHz);
      assert (!o_bullet_flying && o_fleet_x == 0 && o_fleet_y == FLEET_START_ROW)
         else stop_on_error("playfield moved while run was clear");

      $display("No errors");
      $finish;
   end

endmodule

// File: list.f
src/invaders_pkg.sv
src/shot_if.sv
src/tick_timer.sv
src/game_config.sv
src/ship_control.sv
src/bullet.sv
src/alien_fleet.sv
src/invaders_top.sv
verif/invaders_tb.sv

// File: Bender.yml
package:
  name: invaders

sources:
  - src/invaders_pkg.sv
  - src/shot_if.sv
  - src/tick_timer.sv
  - src/game_config.sv
  - src/ship_control.sv
  - src/bullet.sv
  - src/alien_fleet.sv
  - src/invaders_top.sv
  - target: test
    files:
      - verif/invaders_tb.sv
